// ==== include/fe_settings.svh ====
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// settings bus register base of each front end
`define FE_SR_TX_BASE     224
`define FE_SR_RX_BASE     232

// datapath and settings bus widths
`define FE_SAMPLE_W       16
`define FE_SR_ADDR_W      8
`define FE_SR_DATA_W      32

`define FE_NUM_RADIOS     2      // one channel per radio

// pps input handling
`define FE_SYNC_STAGES    2      // metastability flops
`define FE_PPS_TIMEOUT    1000   // short so the watchdog trips in sim
`define FE_PPS_CNT_W      11     // must hold FE_PPS_TIMEOUT

`endif

// ==== hdl/fe_sample_pkg.sv ====
`include "fe_settings.svh"

package fe_sample_pkg;

   typedef logic signed [`FE_SAMPLE_W-1:0] sample_t;

   typedef struct packed {
      sample_t i;   // upper half of the word
      sample_t q;
   } iq_sample_t;

   typedef logic [`FE_PPS_CNT_W-1:0] pps_cnt_t;

   localparam sample_t SAMPLE_MAX = {1'b0, {(`FE_SAMPLE_W-1){1'b1}}};
   localparam sample_t SAMPLE_MIN = {1'b1, {(`FE_SAMPLE_W-1){1'b0}}};

   // signed add clamped to the sample range
   function automatic sample_t sat_add(input sample_t a, input sample_t b);
      logic signed [`FE_SAMPLE_W:0] sum;
      sum = {a[`FE_SAMPLE_W-1], a} + {b[`FE_SAMPLE_W-1], b};
      if (sum[`FE_SAMPLE_W] != sum[`FE_SAMPLE_W-1]) begin
         return sum[`FE_SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;   // overflowed
      end
      return sum[`FE_SAMPLE_W-1:0];
   endfunction

endpackage

// ==== hdl/fe_regmap_pkg.sv ====
`include "fe_settings.svh"

package fe_regmap_pkg;

   import fe_sample_pkg::*;

   typedef logic [`FE_SR_ADDR_W-1:0] sr_addr_t;
   typedef logic [`FE_SR_DATA_W-1:0] sr_data_t;

   typedef struct packed {
      logic     stb;
      sr_addr_t addr;
      sr_data_t data;
   } fe_set_bus_t;

   typedef logic [1:0] tx_mux_t;
   typedef logic [1:0] rx_iq_map_t;

   localparam tx_mux_t    TX_MUX_NORMAL = 2'd0;
   localparam tx_mux_t    TX_MUX_SWAP   = 2'd1;
   localparam tx_mux_t    TX_MUX_I_ONLY = 2'd2;   // 3 behaves as normal

   localparam rx_iq_map_t RX_MAP_NORMAL = 2'd0;
   localparam rx_iq_map_t RX_MAP_SWAP   = 2'd1;
   localparam rx_iq_map_t RX_MAP_REAL   = 2'd2;
   localparam rx_iq_map_t RX_MAP_CONJ   = 2'd3;

   typedef struct packed {
      sample_t offset_i;
      sample_t offset_q;
      tx_mux_t mux;
   } tx_fe_cfg_t;

   typedef struct packed {
      sample_t    offset_i;
      sample_t    offset_q;
      rx_iq_map_t iq_map;
   } rx_fe_cfg_t;

endpackage

// ==== hdl/fe_config_regs.sv ====
`timescale 1ns/10ps
`include "fe_settings.svh"

module fe_config_regs
   import fe_sample_pkg::*, fe_regmap_pkg::*;
(
   input  logic        radio_clk,
   input  logic        i_rst_n,
   input  fe_set_bus_t i_set,
   output tx_fe_cfg_t  o_tx_cfg,
   output rx_fe_cfg_t  o_rx_cfg
);

   ////////////////////////////////////////////////////////////
   // register addresses
   ////////////////////////////////////////////////////////////
   localparam sr_addr_t SR_TX_OFFSET_I = sr_addr_t'(`FE_SR_TX_BASE + 0);
   localparam sr_addr_t SR_TX_OFFSET_Q = sr_addr_t'(`FE_SR_TX_BASE + 1);
   localparam sr_addr_t SR_TX_MUX      = sr_addr_t'(`FE_SR_TX_BASE + 4);
   localparam sr_addr_t SR_RX_OFFSET_I = sr_addr_t'(`FE_SR_RX_BASE + 2);
   localparam sr_addr_t SR_RX_OFFSET_Q = sr_addr_t'(`FE_SR_RX_BASE + 3);
   localparam sr_addr_t SR_RX_IQ_MAP   = sr_addr_t'(`FE_SR_RX_BASE + 4);

   sample_t set_offset;   // offset field of the data word
   logic [1:0] set_mode;  // mode field of the data word

   assign set_offset = sample_t'(i_set.data[`FE_SAMPLE_W-1:0]);
   assign set_mode   = i_set.data[1:0];

   ////////////////////////////////////////////////////////////
   // decode and load
   ////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_tx_cfg <= '0;   // zero config is pass-through
         o_rx_cfg <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_TX_OFFSET_I: o_tx_cfg.offset_i <= set_offset;
            SR_TX_OFFSET_Q: o_tx_cfg.offset_q <= set_offset;
            SR_TX_MUX:      o_tx_cfg.mux      <= tx_mux_t'(set_mode);
            SR_RX_OFFSET_I: o_rx_cfg.offset_i <= set_offset;
            SR_RX_OFFSET_Q: o_rx_cfg.offset_q <= set_offset;
            SR_RX_IQ_MAP:   o_rx_cfg.iq_map   <= rx_iq_map_t'(set_mode);
            default: ;      // mag/phase, het and foreign addresses
         endcase
      end
   end

   // an unknown address would silently pick some register
   a_addr_known: assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      i_set.stb |-> !$isunknown(i_set.addr)
   ) else $error("settings address has unknown bits while stb is high");

endmodule

// ==== hdl/tx_frontend.sv ====
`timescale 1ns/10ps

module tx_frontend
   import fe_sample_pkg::*, fe_regmap_pkg::*;
(
   input  logic       radio_clk,
   input  logic       i_rst_n,
   input  tx_fe_cfg_t i_cfg,
   input  iq_sample_t i_tx,
   input  logic       i_tx_stb,
   output iq_sample_t o_dac,
   output logic       o_dac_stb
);

   iq_sample_t muxed;      // after i/q arrangement
   iq_sample_t corrected;  // after dc offset

   ////////////////////////////////////////////////////////////
   // i/q mux then saturating dc offset
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (i_cfg.mux)
         TX_MUX_NORMAL: muxed = i_tx;
         TX_MUX_SWAP: begin
            muxed.i = i_tx.q;
            muxed.q = i_tx.i;
         end
         TX_MUX_I_ONLY: begin
            muxed.i = i_tx.i;
            muxed.q = '0;
         end
         default: muxed = i_tx;   // mode 3 acts as normal
      endcase
      corrected.i = sat_add(muxed.i, i_cfg.offset_i);
      corrected.q = sat_add(muxed.q, i_cfg.offset_q);
   end

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_dac_stb <= 1'b0;
      end else begin
         o_dac_stb <= i_tx_stb;   // one cycle behind the input
      end
   end

   always_ff @(posedge radio_clk) begin
      o_dac <= corrected;
   end

   // unknown bits on a strobed sample would reach the dac
   a_tx_known: assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      i_tx_stb |-> !$isunknown(i_tx)
   ) else $error("i_tx has unknown bits while i_tx_stb is high");

endmodule

// ==== hdl/rx_frontend.sv ====
`timescale 1ns/10ps

module rx_frontend
   import fe_sample_pkg::*, fe_regmap_pkg::*;
(
   input  logic       radio_clk,
   input  logic       i_rst_n,
   input  rx_fe_cfg_t i_cfg,
   input  iq_sample_t i_adc,
   input  logic       i_adc_stb,
   output iq_sample_t o_rx,
   output logic       o_rx_stb
);

   iq_sample_t mapped;     // after i/q mapping
   iq_sample_t corrected;  // after dc offset
   sample_t    q_neg;      // clamped negation of q

   assign q_neg = (i_adc.q == SAMPLE_MIN) ? SAMPLE_MAX : -i_adc.q;

   ////////////////////////////////////////////////////////////
   // i/q mapping then saturating dc offset
   ////////////////////////////////////////////////////////////
   always_comb begin
      mapped = i_adc;
      case (i_cfg.iq_map)
         RX_MAP_SWAP: begin
            mapped.i = i_adc.q;
            mapped.q = i_adc.i;
         end
         RX_MAP_REAL: mapped.q = '0;     // real mode drops q
         RX_MAP_CONJ: mapped.q = q_neg;  // conjugate
         default: ;                      // normal
      endcase
      corrected.i = sat_add(mapped.i, i_cfg.offset_i);
      corrected.q = sat_add(mapped.q, i_cfg.offset_q);
   end

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rx_stb <= 1'b0;
      end else begin
         o_rx_stb <= i_adc_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      o_rx <= corrected;   // corrected sample
   end

   // unknown bits on a strobed sample would reach the receive chain
   a_adc_known: assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      i_adc_stb |-> !$isunknown(i_adc)
   ) else $error("i_adc has unknown bits while i_adc_stb is high");

endmodule

// ==== hdl/pps_sync.sv ====
`timescale 1ns/10ps
`include "fe_settings.svh"

module pps_sync
   import fe_sample_pkg::*;
(
   input  logic radio_clk,
   input  logic i_rst_n,
   input  logic i_pps,
   output logic o_pps_pulse,
   output logic o_pps_present
);

   localparam int       SYNC_STAGES  = `FE_SYNC_STAGES;
   localparam pps_cnt_t TIMEOUT_LAST = pps_cnt_t'(`FE_PPS_TIMEOUT - 1);

   logic [SYNC_STAGES-1:0] sync_q;   // i_pps enters at bit 0
   logic                   pps_prev;
   logic                   pps_rise;
   pps_cnt_t               idle_cnt; // cycles since the last edge

   assign pps_rise = sync_q[SYNC_STAGES-1] & ~pps_prev;

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sync_q      <= '0;
         pps_prev    <= 1'b0;
         o_pps_pulse <= 1'b0;
      end else begin
         sync_q      <= {sync_q[SYNC_STAGES-2:0], i_pps};
         pps_prev    <= sync_q[SYNC_STAGES-1];
         o_pps_pulse <= pps_rise;
      end
   end

   ////////////////////////////////////////////////////////////
   // presence watchdog
   ////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         idle_cnt      <= '0;
         o_pps_present <= 1'b0;
      end else if (pps_rise) begin
         idle_cnt      <= '0;     // restart on every edge
         o_pps_present <= 1'b1;   // rises together with the pulse
      end else if (o_pps_present) begin
         if (idle_cnt == TIMEOUT_LAST) begin
            o_pps_present <= 1'b0;
         end
         idle_cnt <= idle_cnt + 1'b1;
      end
   end

   // a held pps edge reaches the pulse output through the synchronizer
   a_pulse_latency: assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      $rose(i_pps) |-> ##[2:4] o_pps_pulse
   ) else $error("no o_pps_pulse within 2 to 4 cycles of a rising i_pps");

endmodule

// ==== hdl/radio_fe_top.sv ====
`timescale 1ns/10ps
`include "fe_settings.svh"

module radio_fe_top
   import fe_sample_pkg::*, fe_regmap_pkg::*;
(
   input  logic                                  radio_clk,
   input  logic                                  i_rst_n,

   // one settings bus per radio
   input  fe_set_bus_t [`FE_NUM_RADIOS-1:0] i_set,

   // transmit path
   input  iq_sample_t  [`FE_NUM_RADIOS-1:0] i_tx,
   input  logic        [`FE_NUM_RADIOS-1:0] i_tx_stb,
   output iq_sample_t  [`FE_NUM_RADIOS-1:0] o_dac,
   output logic        [`FE_NUM_RADIOS-1:0] o_dac_stb,

   // receive path
   input  iq_sample_t  [`FE_NUM_RADIOS-1:0] i_adc,
   input  logic        [`FE_NUM_RADIOS-1:0] i_adc_stb,
   output iq_sample_t  [`FE_NUM_RADIOS-1:0] o_rx,
   output logic        [`FE_NUM_RADIOS-1:0] o_rx_stb,

   // pps shared by both radios
   input  logic                                  i_pps,
   output logic                                  o_pps_pulse,
   output logic                                  o_pps_present
);

   tx_fe_cfg_t [`FE_NUM_RADIOS-1:0] tx_cfg;   // decoded per radio
   rx_fe_cfg_t [`FE_NUM_RADIOS-1:0] rx_cfg;

   ////////////////////////////////////////////////////////////
   // per-radio registers and front ends
   ////////////////////////////////////////////////////////////
   for (genvar r = 0; r < `FE_NUM_RADIOS; r++) begin : g_radio

      fe_config_regs u_regs (
         .radio_clk (radio_clk),
         .i_rst_n   (i_rst_n),
         .i_set     (i_set[r]),
         .o_tx_cfg  (tx_cfg[r]),
         .o_rx_cfg  (rx_cfg[r])
      );

      tx_frontend u_tx_fe (
         .radio_clk (radio_clk),
         .i_rst_n   (i_rst_n),
         .i_cfg     (tx_cfg[r]),
         .i_tx      (i_tx[r]),
         .i_tx_stb  (i_tx_stb[r]),
         .o_dac     (o_dac[r]),
         .o_dac_stb (o_dac_stb[r])
      );

      rx_frontend u_rx_fe (
         .radio_clk (radio_clk),
         .i_rst_n   (i_rst_n),
         .i_cfg     (rx_cfg[r]),
         .i_adc     (i_adc[r]),
         .i_adc_stb (i_adc_stb[r]),
         .o_rx      (o_rx[r]),
         .o_rx_stb  (o_rx_stb[r])
      );

   end

   ////////////////////////////////////////////////////////////
   // pps
   ////////////////////////////////////////////////////////////
   pps_sync u_pps_sync (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_pps         (i_pps),       // asynchronous
      .o_pps_pulse   (o_pps_pulse),
      .o_pps_present (o_pps_present)
   );

endmodule

// ==== verif/radio_fe_tb.sv ====
`timescale 1ns/10ps
`include "fe_settings.svh"

module radio_fe_tb
   import fe_sample_pkg::*, fe_regmap_pkg::*;
();

   localparam int N               = `FE_NUM_RADIOS;
   localparam int IDX_W           = (N > 1) ? $clog2(N) : 1;
   localparam int WATCHDOG_CYCLES = 3 * `FE_PPS_TIMEOUT + 2000;   // tests plus margin

   typedef logic [IDX_W-1:0] radio_idx_t;
   localparam radio_idx_t RADIO_0 = radio_idx_t'(0);
   localparam radio_idx_t RADIO_1 = radio_idx_t'(1);

   logic radio_clk, i_rst_n, i_pps, o_pps_pulse, o_pps_present;
   fe_set_bus_t [N-1:0] i_set;
   iq_sample_t  [N-1:0] i_tx, o_dac, i_adc, o_rx;
   logic        [N-1:0] i_tx_stb, o_dac_stb, i_adc_stb, o_rx_stb;

   tx_fe_cfg_t  tx_model [N];        // expected register contents
   rx_fe_cfg_t  rx_model [N];
   logic [31:0] rng_state = 32'h6b0a;
   int          errors    = 0;

   radio_fe_top UUT (.*);

   initial begin
      radio_clk = 1'b0;
      forever #5 radio_clk = ~radio_clk;   // 100 MHz
   end

   ////////////////////////////////////////////////////////////
   // stimulus and reference model
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic iq_sample_t rand_iq();
      logic [31:0] a, b;
      a = next_rand();
      b = next_rand();
      return iq_sample_t'({a[31:16], b[31:16]});   // upper lcg bits spread better
   endfunction

   function automatic iq_sample_t mk_iq(input int i, input int q);
      iq_sample_t s;
      s.i = sample_t'(i);
      s.q = sample_t'(q);
      return s;
   endfunction

   function automatic sample_t clamp_int(input int v);
      if (v > 32767) return sample_t'(32767);
      if (v < -32768) return sample_t'(-32768);
      return sample_t'(v);
   endfunction

   function automatic sample_t add_clamped(input sample_t a, input sample_t b);
      return clamp_int(int'(a) + int'(b));
   endfunction

   function automatic sample_t neg_clamped(input sample_t a);
      return clamp_int(-int'(a));
   endfunction

   function automatic iq_sample_t exp_tx(input tx_fe_cfg_t cfg, input iq_sample_t s);
      iq_sample_t m;
      m = s;
      if (cfg.mux == 2'd1) begin
         m.i = s.q;
         m.q = s.i;
      end else if (cfg.mux == 2'd2) begin
         m.q = '0;   // i only
      end
      m.i = add_clamped(m.i, cfg.offset_i);
      m.q = add_clamped(m.q, cfg.offset_q);
      return m;
   endfunction

   function automatic iq_sample_t exp_rx(input rx_fe_cfg_t cfg, input iq_sample_t s);
      iq_sample_t m;
      m = s;
      case (cfg.iq_map)
         2'd1: begin
            m.i = s.q;
            m.q = s.i;
         end
         2'd2: m.q = '0;
         2'd3: m.q = neg_clamped(s.q);   // conjugate
         default: ;
      endcase
      m.i = add_clamped(m.i, cfg.offset_i);
      m.q = add_clamped(m.q, cfg.offset_q);
      return m;
   endfunction

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////
   task automatic check_iq(input string name, input iq_sample_t exp, input iq_sample_t act);
      if (exp !== act) begin
         errors++;
         $display("ERROR %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         errors++;
         $display("ERROR %s: expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (exp != act) begin
         errors++;
         $display("ERROR %s: expected %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic drive_samples(input iq_sample_t [N-1:0] tx_v, input logic [N-1:0] tx_stb,
                                input iq_sample_t [N-1:0] adc_v, input logic [N-1:0] adc_stb);
      @(posedge radio_clk);
      i_tx      <= tx_v;
      i_tx_stb  <= tx_stb;
      i_adc     <= adc_v;
      i_adc_stb <= adc_stb;
   endtask

   task automatic write_reg(input radio_idx_t r, input sr_addr_t addr, input sr_data_t data);
      fe_set_bus_t [N-1:0] set_v;
      set_v         = '0;
      set_v[r].stb  = 1'b1;
      set_v[r].addr = addr;
      set_v[r].data = data;
      @(posedge radio_clk);
      i_set <= set_v;
      @(posedge radio_clk);
      i_set <= '0;
      case (addr)   // offsets in the low 16 bits and modes in the low 2
         sr_addr_t'(`FE_SR_TX_BASE + 0): tx_model[r].offset_i = sample_t'(data[15:0]);
         sr_addr_t'(`FE_SR_TX_BASE + 1): tx_model[r].offset_q = sample_t'(data[15:0]);
         sr_addr_t'(`FE_SR_TX_BASE + 4): tx_model[r].mux      = data[1:0];
         sr_addr_t'(`FE_SR_RX_BASE + 2): rx_model[r].offset_i = sample_t'(data[15:0]);
         sr_addr_t'(`FE_SR_RX_BASE + 3): rx_model[r].offset_q = sample_t'(data[15:0]);
         sr_addr_t'(`FE_SR_RX_BASE + 4): rx_model[r].iq_map   = data[1:0];
         default: ;
      endcase
   endtask

   // one strobed sample on radio r checked one cycle later
   task automatic check_one(input string name, input radio_idx_t r,
                            input iq_sample_t tx_s, input iq_sample_t adc_s);
      iq_sample_t [N-1:0] tx_v, adc_v;
      logic       [N-1:0] stb_v;
      tx_v     = '0;
      adc_v    = '0;
      stb_v    = '0;
      tx_v[r]  = tx_s;
      adc_v[r] = adc_s;
      stb_v[r] = 1'b1;
      drive_samples(tx_v, stb_v, adc_v, stb_v);
      drive_samples('0, '0, '0, '0);
      @(negedge radio_clk);
      check_bit({name, " dac_stb"}, 1'b1, o_dac_stb[r]);
      check_iq({name, " dac"}, exp_tx(tx_model[r], tx_s), o_dac[r]);
      check_bit({name, " rx_stb"}, 1'b1, o_rx_stb[r]);
      check_iq({name, " rx"}, exp_rx(rx_model[r], adc_s), o_rx[r]);
   endtask

   // random samples and strobes on all radios every cycle
   task automatic stream(input string name, input int n);
      iq_sample_t [N-1:0] tx_v, adc_v, tx_prev, adc_prev;
      logic       [N-1:0] tx_stb_v, adc_stb_v, tx_stb_prev, adc_stb_prev;
      radio_idx_t         rr;
      logic [31:0]        rnd;
      for (int k = 0; k <= n; k++) begin
         tx_v      = '0;
         adc_v     = '0;
         tx_stb_v  = '0;
         adc_stb_v = '0;
         for (int j = 0; j < N && k < n; j++) begin
            rr            = radio_idx_t'(j);
            tx_v[rr]      = rand_iq();
            adc_v[rr]     = rand_iq();
            rnd           = next_rand();
            tx_stb_v[rr]  = rnd[31];
            adc_stb_v[rr] = rnd[30];
         end
         drive_samples(tx_v, tx_stb_v, adc_v, adc_stb_v);
         @(negedge radio_clk);   // outputs now hold the previous cycle
         for (int j = 0; j < N && k > 0; j++) begin
            rr = radio_idx_t'(j);
            check_bit({name, " dac_stb"}, tx_stb_prev[rr], o_dac_stb[rr]);
            check_bit({name, " rx_stb"}, adc_stb_prev[rr], o_rx_stb[rr]);
            if (tx_stb_prev[rr]) begin
               check_iq({name, " dac"}, exp_tx(tx_model[rr], tx_prev[rr]), o_dac[rr]);
            end
            if (adc_stb_prev[rr]) begin
               check_iq({name, " rx"}, exp_rx(rx_model[rr], adc_prev[rr]), o_rx[rr]);
            end
         end
         tx_prev      = tx_v;
         adc_prev     = adc_v;
         tx_stb_prev  = tx_stb_v;
         adc_stb_prev = adc_stb_v;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////
   task automatic test_reset_passthrough();
      @(negedge radio_clk);
      check_bit("reset dac_stb", 1'b0, |o_dac_stb);
      check_bit("reset rx_stb", 1'b0, |o_rx_stb);
      check_bit("reset pps_present", 1'b0, o_pps_present);
      stream("reset_passthrough", 40);
   endtask

   task automatic test_tx_offset();
      write_reg(RADIO_0, sr_addr_t'(`FE_SR_TX_BASE + 0), 32'd100);
      write_reg(RADIO_0, sr_addr_t'(`FE_SR_TX_BASE + 1), 32'h0000_ff38);   // -200
      check_one("tx_offset clamp", RADIO_0, mk_iq(32700, -32700), rand_iq());
      check_one("tx_offset exact", RADIO_0, mk_iq(32667, -32568), rand_iq());
      check_one("tx_offset rand", RADIO_0, rand_iq(), rand_iq());
      write_reg(RADIO_0, sr_addr_t'(`FE_SR_TX_BASE + 0), 32'h0000_7fff);
      write_reg(RADIO_0, sr_addr_t'(`FE_SR_TX_BASE + 1), 32'hffff_8000);   // upper bits ignored
      check_one("tx_offset extreme", RADIO_0, mk_iq(1, -1), rand_iq());
      check_one("tx_offset opposite", RADIO_0, mk_iq(-32768, 32767), rand_iq());
      stream("tx_offset_stream", 16);
      check_one("tx_offset radio1", RADIO_1, rand_iq(), rand_iq());
   endtask

   task automatic test_tx_mux();
      write_reg(RADIO_0, sr_addr_t'(`FE_SR_TX_BASE + 0), 32'd0);
      write_reg(RADIO_0, sr_addr_t'(`FE_SR_TX_BASE + 1), 32'd0);
      for (int m = 0; m < 4; m++) begin
         write_reg(RADIO_0, sr_addr_t'(`FE_SR_TX_BASE + 4), sr_data_t'(m));
         check_one($sformatf("tx_mux%0d", m), RADIO_0, mk_iq(1234, -4321), rand_iq());
         stream($sformatf("tx_mux%0d_stream", m), 8);
      end
   endtask

   task automatic test_rx_map();
      write_reg(RADIO_1, sr_addr_t'(`FE_SR_RX_BASE + 2), 32'd50);
      write_reg(RADIO_1, sr_addr_t'(`FE_SR_RX_BASE + 3), 32'h0000_ffce);   // -50
      for (int m = 0; m < 4; m++) begin
         write_reg(RADIO_1, sr_addr_t'(`FE_SR_RX_BASE + 4), sr_data_t'(m));
         check_one($sformatf("rx_map%0d edge", m), RADIO_1, rand_iq(), mk_iq(32760, -32768));
         check_one($sformatf("rx_map%0d rand", m), RADIO_1, rand_iq(), rand_iq());
         stream($sformatf("rx_map%0d_stream", m), 8);
      end
   endtask

   task automatic test_reg_isolation();
      sr_addr_t ignored [6];
      ignored = '{sr_addr_t'(`FE_SR_TX_BASE + 2), sr_addr_t'(`FE_SR_RX_BASE + 0),
                  sr_addr_t'(`FE_SR_RX_BASE + 5), sr_addr_t'(8'h10),
                  sr_addr_t'(`FE_SR_TX_BASE + 3), sr_addr_t'(8'hff)};
      for (int k = 0; k < 6; k++) begin
         write_reg(RADIO_0, ignored[k], next_rand());
         write_reg(RADIO_1, ignored[k], next_rand());
      end
      write_reg(RADIO_1, sr_addr_t'(`FE_SR_TX_BASE + 0), 32'd777);   // rx side must not move
      write_reg(RADIO_1, sr_addr_t'(`FE_SR_TX_BASE + 4), 32'd1);
      stream("reg_isolation", 20);
   endtask

   task automatic test_pps();
      int pulses, first_cyc;
      for (int n = 0; n < 3; n++) begin
         @(posedge radio_clk);
         i_pps     <= 1'b1;
         pulses    = 0;
         first_cyc = -1;
         for (int c = 0; c < 8; c++) begin
            @(negedge radio_clk);
            if (o_pps_pulse) begin
               pulses++;
               if (first_cyc < 0) first_cyc = c;
            end
         end
         check_count("pps pulse count", 1, pulses);
         if (first_cyc < 2 || first_cyc > 4) begin
            errors++;
            $display("ERROR pps delay: expected 2 to 4 cycles actual %0d", first_cyc);
         end
         check_bit("pps present", 1'b1, o_pps_present);
         @(posedge radio_clk);
         i_pps <= 1'b0;
         repeat (100) @(posedge radio_clk);   // well inside the timeout
      end
      repeat (`FE_PPS_TIMEOUT + 10) @(posedge radio_clk);
      @(negedge radio_clk);
      check_bit("pps present timeout", 1'b0, o_pps_present);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////
   initial begin
      i_rst_n   = 1'b0;
      i_pps     = 1'b0;
      i_set     = '0;
      i_tx      = '0;
      i_tx_stb  = '0;
      i_adc     = '0;
      i_adc_stb = '0;
      tx_model  = '{default: '0};
      rx_model  = '{default: '0};
      repeat (16) @(posedge radio_clk);
      i_rst_n <= 1'b1;
      test_reset_passthrough();
      test_tx_offset();
      test_tx_mux();
      test_rx_map();
      test_reg_isolation();
      test_pps();
      $display("run complete, errors: %0d", errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge radio_clk);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/fe_sample_pkg.sv
hdl/fe_regmap_pkg.sv
hdl/fe_config_regs.sv
hdl/tx_frontend.sv
hdl/rx_frontend.sv
hdl/pps_sync.sv
hdl/radio_fe_top.sv
verif/radio_fe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= radio_fe_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
